//--- hw/aud_pkg.sv
package aud_pkg;

	// pcm word width from the codec
	localparam int SAMPLE_W = 16;

	// one left-channel sample, two's complement
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// playback modes, switch encoding
	// bit 1 selects fast or interpolated, bit 0 selects slow
	typedef enum logic [1:0] {
		PLAY_NORMAL      = 2'b00,
		PLAY_SLOW_HOLD   = 2'b01,
		PLAY_FAST        = 2'b10,
		PLAY_SLOW_INTERP = 2'b11
	} play_mode_e;

	// latched at play start
	// speed 0 means factor 1, speed 7 means factor 8
	typedef struct packed {
		play_mode_e mode;
		logic [2:0] speed;
	} play_cfg_t;

endpackage

//--- hw/ctrl_pkg.sv
package ctrl_pkg;

	// on-chip sample store in place of the board sram
	localparam int MEM_AW    = 6;
	localparam int MEM_DEPTH = 2 ** MEM_AW;

	// word address into the sample store
	typedef logic [MEM_AW-1:0] addr_t;

	// record length, one bit wider to hold a full store
	typedef logic [MEM_AW:0] len_t;

	// top-level sequencing
	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_RECORD = 2'd1,
		ST_PLAY   = 2'd2,
		ST_PAUSE  = 2'd3
	} ctrl_state_e;

	// recorder to memory write word
	typedef struct packed {
		aud_pkg::sample_t data;
	} mem_wr_t;

endpackage

//--- hw/aud_recorder.sv
`timescale 1ns/100ps

module aud_recorder (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_en,
	input  logic              i_bclk,
	input  logic              i_adc_lrck,
	input  logic              i_adcdat,
	input  logic              i_wr_ready,
	output ctrl_pkg::mem_wr_t o_wr,
	output logic              o_wr_valid
);

	// frame tracking
	typedef enum logic [1:0] {
		R_WAIT,
		R_DELAY,
		R_SHIFT
	} rec_state_e;

	rec_state_e       state;
	logic             bclk_q;
	logic             lrck_q;
	logic             bclk_rise;
	logic             lrck_fall;
	logic [3:0]       bit_cnt;
	aud_pkg::sample_t shift_q;
	logic             word_done;

	// one-stage edge detect on the slow codec clocks
	assign bclk_rise = i_bclk && !bclk_q;
	assign lrck_fall = !i_adc_lrck && lrck_q;

	// 16th data rise of the left half
	assign word_done = i_en && (state == R_SHIFT) && bclk_rise && (bit_cnt == 4'd15);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state      <= R_WAIT;
			bit_cnt    <= 4'd0;
			bclk_q     <= 1'b0;
			lrck_q     <= 1'b0;
			o_wr_valid <= 1'b0;
		end
		else begin
			bclk_q <= i_bclk;
			lrck_q <= i_adc_lrck;
			if (!i_en) begin
				// drop anything half done, resync on next frame
				state      <= R_WAIT;
				o_wr_valid <= 1'b0;
			end
			else begin
				if (o_wr_valid && i_wr_ready) begin
					o_wr_valid <= 1'b0;
				end
				case (state)
					// left half starts when lrck goes low
					R_WAIT: begin
						if (lrck_fall) begin
							state <= R_DELAY;
						end
					end
					// i2s one-bit delay, skip this rise
					R_DELAY: begin
						if (bclk_rise) begin
							state   <= R_SHIFT;
							bit_cnt <= 4'd0;
						end
					end
					R_SHIFT: begin
						if (bclk_rise) begin
							bit_cnt <= bit_cnt + 4'd1;
							// right half ignored, back to waiting
							if (bit_cnt == 4'd15) begin
								state <= R_WAIT;
							end
						end
					end
					default: begin
						state <= R_WAIT;
					end
				endcase
				// fresh word wins over an unaccepted one
				if (word_done) begin
					o_wr_valid <= 1'b1;
				end
			end
		end
	end

	// msb first shift, payload only
	always_ff @(posedge i_clk) begin
		if ((state == R_SHIFT) && bclk_rise) begin
			shift_q <= {shift_q[aud_pkg::SAMPLE_W-2:0], i_adcdat};
		end
		if (word_done) begin
			o_wr.data <= {shift_q[aud_pkg::SAMPLE_W-2:0], i_adcdat};
		end
	end

	// pending word held until the memory takes it
	// only a newly finished frame may replace it
	a_wr_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_wr_valid && !i_wr_ready && !word_done |=> $stable(o_wr));

endmodule

//--- hw/sample_mem.sv
`timescale 1ns/100ps

module sample_mem (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_clr,
	input  ctrl_pkg::mem_wr_t i_wr,
	input  logic              i_wr_valid,
	input  ctrl_pkg::addr_t   i_rd_addr,
	output logic              o_wr_ready,
	output aud_pkg::sample_t  o_rd_data,
	output ctrl_pkg::len_t    o_rec_len,
	output logic              o_full
);

	aud_pkg::sample_t mem [ctrl_pkg::MEM_DEPTH];
	ctrl_pkg::len_t   wr_len;
	logic             wr_acc;

	// write pointer doubles as record length
	assign o_rec_len = wr_len;
	assign o_full    = (wr_len == ctrl_pkg::len_t'(ctrl_pkg::MEM_DEPTH));

	// no space or clearing, no take
	assign o_wr_ready = !o_full && !i_clr;
	assign wr_acc     = i_wr_valid && o_wr_ready;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			wr_len <= '0;
		end
		else if (i_clr) begin
			wr_len <= '0;
		end
		else if (wr_acc) begin
			wr_len <= wr_len + 1'b1;
		end
	end

	// storage, lands together with the length step
	always_ff @(posedge i_clk) begin
		if (wr_acc) begin
			mem[wr_len[ctrl_pkg::MEM_AW-1:0]] <= i_wr.data;
		end
	end

	// registered read, data one cycle after address
	always_ff @(posedge i_clk) begin
		o_rd_data <= mem[i_rd_addr];
	end

	// once full, length stays put until the next clear
	a_no_wr_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_full && !i_clr |=> o_rec_len == ctrl_pkg::len_t'(ctrl_pkg::MEM_DEPTH));

endmodule

//--- hw/aud_dsp.sv
`timescale 1ns/100ps

module aud_dsp (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_start,
	input  logic               i_run,
	input  aud_pkg::play_cfg_t i_cfg,
	input  ctrl_pkg::len_t     i_len,
	input  aud_pkg::sample_t   i_rd_data,
	input  logic               i_dac_ready,
	output ctrl_pkg::addr_t    o_rd_addr,
	output aud_pkg::sample_t   o_dac_data,
	output logic               o_dac_valid,
	output logic               o_done
);

	// a at index i, b at i+1
	typedef enum logic [2:0] {
		FETCH_A,
		WAIT_A,
		FETCH_B,
		WAIT_B,
		EMIT
	} dsp_state_e;

	dsp_state_e        state;
	logic              active;
	ctrl_pkg::len_t    idx;
	ctrl_pkg::len_t    idx_p1;
	ctrl_pkg::len_t    idx_step;
	logic [2:0]        k;
	logic [3:0]        k_ext;
	logic [3:0]        spd_n;
	logic [3:0]        spd_nk;
	aud_pkg::sample_t  a_q;
	aud_pkg::sample_t  b_q;
	logic signed [21:0] acc;
	logic signed [21:0] quo;
	logic              is_interp;
	logic              more_reps;
	logic              last_idx;
	logic              xfer;

	// speed factor n = speed + 1
	assign spd_n  = {1'b0, i_cfg.speed} + 4'd1;
	assign k_ext  = {1'b0, k};
	assign spd_nk = spd_n - k_ext;

	assign is_interp = (i_cfg.mode == aud_pkg::PLAY_SLOW_INTERP);

	// fast mode strides by n, everything else by one
	assign idx_p1   = idx + 1'b1;
	assign idx_step = (i_cfg.mode == aud_pkg::PLAY_FAST) ? idx + spd_n : idx_p1;
	assign last_idx = (idx_step >= i_len);

	// slow modes repeat n times per index
	assign more_reps = ((i_cfg.mode == aud_pkg::PLAY_SLOW_HOLD) || is_interp) &&
		((k_ext + 4'd1) < spd_n);

	// address held through the wait so a pause keeps the data
	assign o_rd_addr = ((state == FETCH_B) || (state == WAIT_B)) ?
		idx_p1[ctrl_pkg::MEM_AW-1:0] : idx[ctrl_pkg::MEM_AW-1:0];

	// a*(n-k) + b*k over n, signed divide truncates toward zero
	always_comb begin
		acc = a_q * $signed({1'b0, spd_nk}) + b_q * $signed({1'b0, k_ext});
		quo = acc / $signed({1'b0, spd_n});
	end

	assign o_dac_data = is_interp ? quo[aud_pkg::SAMPLE_W-1:0] : a_q;

	// held sample is kept inside while stopped or paused
	assign o_dac_valid = active && (state == EMIT) && i_run;
	assign xfer        = o_dac_valid && i_dac_ready;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state  <= FETCH_A;
			active <= 1'b0;
			idx    <= '0;
			k      <= 3'd0;
			o_done <= 1'b0;
		end
		else begin
			o_done <= 1'b0;
			if (i_start) begin
				state  <= FETCH_A;
				idx    <= '0;
				k      <= 3'd0;
				// empty recording finishes right away
				active <= (i_len != '0);
				o_done <= (i_len == '0);
			end
			else if (active && i_run) begin
				case (state)
					FETCH_A: begin
						state <= WAIT_A;
					end
					WAIT_A: begin
						// b only needed for interpolation, past the end b = a
						if (is_interp && (idx_p1 < i_len)) begin
							state <= FETCH_B;
						end
						else begin
							state <= EMIT;
						end
					end
					FETCH_B: begin
						state <= WAIT_B;
					end
					WAIT_B: begin
						state <= EMIT;
					end
					EMIT: begin
						if (xfer) begin
							if (more_reps) begin
								k <= k + 3'd1;
							end
							else begin
								k     <= 3'd0;
								idx   <= idx_step;
								state <= FETCH_A;
								if (last_idx) begin
									active <= 1'b0;
									o_done <= 1'b1;
								end
							end
						end
					end
					default: begin
						state <= FETCH_A;
					end
				endcase
			end
		end
	end

	// sample latches, no reset
	always_ff @(posedge i_clk) begin
		if (active && i_run && (state == WAIT_A)) begin
			a_q <= i_rd_data;
			b_q <= i_rd_data;
		end
		if (active && i_run && (state == WAIT_B)) begin
			b_q <= i_rd_data;
		end
	end

	// stalled output word must not move
	a_dac_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_dac_valid && !i_dac_ready |=> !i_run || $stable(o_dac_data));

endmodule

//--- hw/rec_play_ctrl.sv
`timescale 1ns/100ps

module rec_play_ctrl (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_start,
	input  logic                  i_pause,
	input  logic                  i_stop,
	input  logic                  i_rec_play,
	input  aud_pkg::play_mode_e   i_mode,
	input  logic [2:0]            i_speed,
	input  logic                  i_full,
	input  logic                  i_done,
	output logic                  o_rec_en,
	output logic                  o_mem_clr,
	output logic                  o_play_start,
	output logic                  o_play_run,
	output aud_pkg::play_cfg_t    o_cfg,
	output ctrl_pkg::ctrl_state_e o_state
);

	ctrl_pkg::ctrl_state_e state;
	ctrl_pkg::ctrl_state_e state_nxt;
	logic                  go_rec;
	logic                  go_play;

	// i_rec_play  0 record, 1 play
	assign go_rec  = (state == ctrl_pkg::ST_IDLE) && i_start && !i_rec_play;
	assign go_play = (state == ctrl_pkg::ST_IDLE) && i_start && i_rec_play;

	always_comb begin
		state_nxt = state;
		case (state)
			ctrl_pkg::ST_IDLE: begin
				if (go_rec) begin
					state_nxt = ctrl_pkg::ST_RECORD;
				end
				else if (go_play) begin
					state_nxt = ctrl_pkg::ST_PLAY;
				end
			end
			ctrl_pkg::ST_RECORD: begin
				// full is stale during the clear cycle
				if (i_stop || (i_full && !o_mem_clr)) begin
					state_nxt = ctrl_pkg::ST_IDLE;
				end
			end
			ctrl_pkg::ST_PLAY: begin
				if (i_stop || i_done) begin
					state_nxt = ctrl_pkg::ST_IDLE;
				end
				else if (i_pause) begin
					state_nxt = ctrl_pkg::ST_PAUSE;
				end
			end
			ctrl_pkg::ST_PAUSE: begin
				// start resumes, no restart pulse
				if (i_stop) begin
					state_nxt = ctrl_pkg::ST_IDLE;
				end
				else if (i_start) begin
					state_nxt = ctrl_pkg::ST_PLAY;
				end
			end
			default: begin
				state_nxt = ctrl_pkg::ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state        <= ctrl_pkg::ST_IDLE;
			o_mem_clr    <= 1'b0;
			o_play_start <= 1'b0;
			o_cfg        <= '{mode: aud_pkg::PLAY_NORMAL, speed: 3'd0};
		end
		else begin
			state        <= state_nxt;
			// pulses line up with the first cycle of the new state
			o_mem_clr    <= go_rec;
			o_play_start <= go_play;
			if (go_play) begin
				o_cfg <= '{mode: i_mode, speed: i_speed};
			end
		end
	end

	assign o_rec_en   = (state == ctrl_pkg::ST_RECORD);
	assign o_play_run = (state == ctrl_pkg::ST_PLAY);
	assign o_state    = state;

	// record never hands over straight to play
	a_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_rec_en |-> !o_play_run ##1 !o_play_run);

endmodule

//--- hw/aud_top.sv
`timescale 1ns/100ps

module aud_top (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_start,
	input  logic                  i_pause,
	input  logic                  i_stop,
	input  logic                  i_rec_play,
	input  aud_pkg::play_mode_e   i_mode,
	input  logic [2:0]            i_speed,
	input  logic                  i_bclk,
	input  logic                  i_adc_lrck,
	input  logic                  i_adcdat,
	input  logic                  i_dac_ready,
	output aud_pkg::sample_t      o_dac_data,
	output logic                  o_dac_valid,
	output ctrl_pkg::ctrl_state_e o_state,
	output ctrl_pkg::len_t        o_rec_len
);

	// recorder to memory
	ctrl_pkg::mem_wr_t  wr;
	logic               wr_valid;
	logic               wr_ready;
	logic               full;

	// memory to dsp
	ctrl_pkg::addr_t    rd_addr;
	aud_pkg::sample_t   rd_data;

	// controller strobes
	logic               rec_en;
	logic               mem_clr;
	logic               play_start;
	logic               play_run;
	logic               play_done;
	aud_pkg::play_cfg_t cfg;

	// adc side producer
	aud_recorder recorder0 (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_en       (rec_en),
		.i_bclk     (i_bclk),
		.i_adc_lrck (i_adc_lrck),
		.i_adcdat   (i_adcdat),
		.i_wr_ready (wr_ready),
		.o_wr       (wr),
		.o_wr_valid (wr_valid)
	);

	// sample buffer, length is the playback end
	sample_mem mem0 (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_clr      (mem_clr),
		.i_wr       (wr),
		.i_wr_valid (wr_valid),
		.i_rd_addr  (rd_addr),
		.o_wr_ready (wr_ready),
		.o_rd_data  (rd_data),
		.o_rec_len  (o_rec_len),
		.o_full     (full)
	);

	// playback consumer
	aud_dsp dsp0 (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_start     (play_start),
		.i_run       (play_run),
		.i_cfg       (cfg),
		.i_len       (o_rec_len),
		.i_rd_data   (rd_data),
		.i_dac_ready (i_dac_ready),
		.o_rd_addr   (rd_addr),
		.o_dac_data  (o_dac_data),
		.o_dac_valid (o_dac_valid),
		.o_done      (play_done)
	);

	// key and switch sequencing
	rec_play_ctrl ctrl0 (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_start      (i_start),
		.i_pause      (i_pause),
		.i_stop       (i_stop),
		.i_rec_play   (i_rec_play),
		.i_mode       (i_mode),
		.i_speed      (i_speed),
		.i_full       (full),
		.i_done       (play_done),
		.o_rec_en     (rec_en),
		.o_mem_clr    (mem_clr),
		.o_play_start (play_start),
		.o_play_run   (play_run),
		.o_cfg        (cfg),
		.o_state      (o_state)
	);

endmodule

//--- tests/aud_tb.sv
`timescale 1ns/100ps

module aud_tb;

	// what to do while a clip plays
	typedef enum {
		ACT_RUN,
		ACT_PAUSE,
		ACT_STOP
	} play_act_e;

	localparam int N_ROWS = 8;

	logic                  i_clk;
	logic                  i_rst_n;
	logic                  i_start;
	logic                  i_pause;
	logic                  i_stop;
	logic                  i_rec_play;
	aud_pkg::play_mode_e   i_mode;
	logic [2:0]            i_speed;
	logic                  i_bclk;
	logic                  i_adc_lrck;
	logic                  i_adcdat;
	logic                  i_dac_ready;
	aud_pkg::sample_t      o_dac_data;
	logic                  o_dac_valid;
	ctrl_pkg::ctrl_state_e o_state;
	ctrl_pkg::len_t        o_rec_len;

	// test table, stimulus plus expected record length
	string               row_name   [N_ROWS];
	int                  row_frames [N_ROWS];
	int                  row_len    [N_ROWS];
	aud_pkg::play_mode_e row_mode   [N_ROWS];
	int                  row_speed  [N_ROWS];
	bit                  row_bp     [N_ROWS];
	play_act_e           row_act    [N_ROWS];

	// reference copy of what the memory should hold
	aud_pkg::sample_t model [ctrl_pkg::MEM_DEPTH];
	aud_pkg::sample_t exp_q [$];
	aud_pkg::sample_t got_q [$];

	bit bp_on;
	int errors;
	int checks;
	int cycles;
	int limit;

	aud_top dut_i (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_start     (i_start),
		.i_pause     (i_pause),
		.i_stop      (i_stop),
		.i_rec_play  (i_rec_play),
		.i_mode      (i_mode),
		.i_speed     (i_speed),
		.i_bclk      (i_bclk),
		.i_adc_lrck  (i_adc_lrck),
		.i_adcdat    (i_adcdat),
		.i_dac_ready (i_dac_ready),
		.o_dac_data  (o_dac_data),
		.o_dac_valid (o_dac_valid),
		.o_state     (o_state),
		.o_rec_len   (o_rec_len)
	);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	// dac back-pressure, random half duty when enabled
	initial begin
		i_dac_ready = 1'b1;
		forever begin
			@(negedge i_clk);
			i_dac_ready = bp_on ? 1'($urandom % 2) : 1'b1;
		end
	end

	// collect every accepted playback word
	always @(posedge i_clk) begin
		if (i_rst_n && o_dac_valid && i_dac_ready) begin
			got_q.push_back(o_dac_data);
		end
	end

	// watchdog on a cycle count
	initial begin
		cycles = 0;
		@(posedge i_clk);
		while (cycles < limit) begin
			@(posedge i_clk);
			cycles++;
		end
		$display("timed out after %0d cycles, DUT never went back to idle", limit);
		$display("TEST FAIL");
		$finish;
	end

	task automatic compare_value(string what, int exp, int act);
		checks++;
		if (exp != act) begin
			errors++;
			$display("Mismatch %s: expected %0d, actual %0d", what, exp, act);
		end
	endtask

	task automatic set_row(int r, string nm, int frames, int len, aud_pkg::play_mode_e m,
		int spd, bit bp, play_act_e act);
		row_name[r]   = nm;
		row_frames[r] = frames;
		row_len[r]    = len;
		row_mode[r]   = m;
		row_speed[r]  = spd;
		row_bp[r]     = bp;
		row_act[r]    = act;
	endtask

	// frames 0 keeps the previous recording
	task automatic load_table();
		set_row(0, "rec20_norm", 20, 20, aud_pkg::PLAY_NORMAL, 0, 1'b0, ACT_RUN);
		set_row(1, "fast_x2", 0, 20, aud_pkg::PLAY_FAST, 1, 1'b0, ACT_RUN);
		set_row(2, "fast_x8", 0, 20, aud_pkg::PLAY_FAST, 7, 1'b1, ACT_RUN);
		set_row(3, "hold_x4", 0, 20, aud_pkg::PLAY_SLOW_HOLD, 3, 1'b1, ACT_RUN);
		set_row(4, "interp_x5", 0, 20, aud_pkg::PLAY_SLOW_INTERP, 4, 1'b1, ACT_RUN);
		set_row(5, "rec70_full", 70, 64, aud_pkg::PLAY_NORMAL, 0, 1'b1, ACT_RUN);
		set_row(6, "stop_play", 0, 64, aud_pkg::PLAY_SLOW_HOLD, 2, 1'b1, ACT_STOP);
		set_row(7, "pause_play", 0, 64, aud_pkg::PLAY_SLOW_INTERP, 2, 1'b1, ACT_PAUSE);
	endtask

	// stream length by mode, for the watchdog budget
	function automatic int count_outputs(aud_pkg::play_mode_e m, int n, int len);
		if (m == aud_pkg::PLAY_NORMAL) begin
			return len;
		end
		if (m == aud_pkg::PLAY_FAST) begin
			return (len + n - 1) / n;
		end
		return len * n;
	endfunction

	// expected output words for one clip
	task automatic expect_stream(aud_pkg::play_mode_e m, int n, int len);
		int i;
		int k;
		int a;
		int b;
		exp_q.delete();
		i = 0;
		while (i < len) begin
			a = model[i];
			// last sample pairs with itself
			b = (i + 1 < len) ? int'(model[i + 1]) : a;
			case (m)
				aud_pkg::PLAY_NORMAL: begin
					exp_q.push_back(aud_pkg::sample_t'(a));
					i = i + 1;
				end
				aud_pkg::PLAY_FAST: begin
					exp_q.push_back(aud_pkg::sample_t'(a));
					i = i + n;
				end
				aud_pkg::PLAY_SLOW_HOLD: begin
					for (k = 0; k < n; k++) begin
						exp_q.push_back(aud_pkg::sample_t'(a));
					end
					i = i + 1;
				end
				default: begin
					// int divide truncates toward zero
					for (k = 0; k < n; k++) begin
						exp_q.push_back(aud_pkg::sample_t'((a * (n - k) + b * k) / n));
					end
					i = i + 1;
				end
			endcase
		end
	endtask

	// one bclk period, 4 system clocks
	task automatic drive_bit(logic lr, logic d);
		i_bclk     = 1'b0;
		i_adc_lrck = lr;
		i_adcdat   = d;
		repeat (2) @(negedge i_clk);
		i_bclk = 1'b1;
		repeat (2) @(negedge i_clk);
	endtask

	// 32-slot i2s frame, left sample msb first after the delay slot
	task automatic serialize_frame(aud_pkg::sample_t s);
		int b;
		drive_bit(1'b0, 1'b0);
		for (b = aud_pkg::SAMPLE_W - 1; b >= 1; b--) begin
			drive_bit(1'b0, s[b]);
		end
		// lsb falls into the first right slot
		drive_bit(1'b1, s[0]);
		// right channel noise
		for (b = 0; b < 15; b++) begin
			drive_bit(1'b1, 1'($urandom % 2));
		end
	endtask

	task automatic record_clip(int r);
		int f;
		aud_pkg::sample_t s;
		i_rec_play = 1'b0;
		i_start    = 1'b1;
		@(negedge i_clk);
		i_start = 1'b0;
		for (f = 0; f < row_frames[r]; f++) begin
			s = aud_pkg::sample_t'($urandom);
			if (f < ctrl_pkg::MEM_DEPTH) begin
				model[f] = s;
			end
			serialize_frame(s);
		end
		repeat (4) @(negedge i_clk);
		// a full store ends recording by itself
		if (row_frames[r] <= ctrl_pkg::MEM_DEPTH) begin
			i_stop = 1'b1;
			@(negedge i_clk);
			i_stop = 1'b0;
			@(negedge i_clk);
		end
		compare_value({row_name[r], " rec state"}, int'(ctrl_pkg::ST_IDLE), int'(o_state));
		compare_value({row_name[r], " rec_len"}, row_len[r], int'(o_rec_len));
	endtask

	task automatic play_clip(int r);
		int hold;
		int j;
		expect_stream(row_mode[r], row_speed[r] + 1, row_len[r]);
		got_q.delete();
		bp_on      = row_bp[r];
		i_rec_play = 1'b1;
		i_mode     = row_mode[r];
		i_speed    = 3'(row_speed[r]);
		i_start    = 1'b1;
		@(negedge i_clk);
		i_start = 1'b0;
		if (row_act[r] == ACT_PAUSE) begin
			while (got_q.size() < 3) @(negedge i_clk);
			i_pause = 1'b1;
			@(negedge i_clk);
			i_pause = 1'b0;
			compare_value({row_name[r], " paused"}, int'(ctrl_pkg::ST_PAUSE), int'(o_state));
			hold = got_q.size();
			repeat (20) @(negedge i_clk);
			// nothing may leave while paused
			compare_value({row_name[r], " words in pause"}, hold, got_q.size());
			i_start = 1'b1;
			@(negedge i_clk);
			i_start = 1'b0;
		end
		if (row_act[r] == ACT_STOP) begin
			while (got_q.size() < 5) @(negedge i_clk);
			i_stop = 1'b1;
			@(negedge i_clk);
			i_stop = 1'b0;
			compare_value({row_name[r], " stop state"}, int'(ctrl_pkg::ST_IDLE), int'(o_state));
			compare_value({row_name[r], " valid after stop"}, 0, int'(o_dac_valid));
			hold = got_q.size();
			repeat (20) @(negedge i_clk);
			// a stopped clip stays silent
			compare_value({row_name[r], " words after stop"}, hold, got_q.size());
		end
		else begin
			while (o_state != ctrl_pkg::ST_IDLE) @(negedge i_clk);
			repeat (2) @(negedge i_clk);
			compare_value({row_name[r], " count"}, exp_q.size(), got_q.size());
		end
		// stopped clips compare the prefix only
		for (j = 0; j < got_q.size() && j < exp_q.size(); j++) begin
			compare_value($sformatf("%s[%0d]", row_name[r], j), exp_q[j], got_q[j]);
		end
		bp_on = 1'b0;
	endtask

	initial begin
		int r;
		int seed_ret;
		int frames_sum;
		int outs_sum;
		int err_before;
		i_rst_n    = 1'b0;
		i_start    = 1'b0;
		i_pause    = 1'b0;
		i_stop     = 1'b0;
		i_rec_play = 1'b0;
		i_mode     = aud_pkg::PLAY_NORMAL;
		i_speed    = 3'd0;
		i_bclk     = 1'b0;
		i_adc_lrck = 1'b1;
		i_adcdat   = 1'b0;
		bp_on      = 1'b0;
		errors     = 0;
		checks     = 0;
		seed_ret   = $urandom(32'h8b78);
		load_table();
		// 128 clocks per frame, about 20 per output word under back-pressure
		frames_sum = 0;
		outs_sum   = 0;
		for (r = 0; r < N_ROWS; r++) begin
			frames_sum += row_frames[r];
			outs_sum   += count_outputs(row_mode[r], row_speed[r] + 1, row_len[r]);
		end
		limit = frames_sum * 130 + outs_sum * 20 + 2000;
		repeat (2) @(negedge i_clk);
		i_rst_n = 1'b1;
		@(negedge i_clk);
		for (r = 0; r < N_ROWS; r++) begin
			err_before = errors;
			if (row_frames[r] > 0) begin
				record_clip(r);
			end
			play_clip(r);
			$display("%-12s %s, %0d errors", row_name[r],
				(errors == err_before) ? "ok" : "failed", errors - err_before);
		end
		$display("tests: %0d, checks: %0d, errors: %0d", N_ROWS, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end
		else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- filelist.f
hw/aud_pkg.sv
hw/ctrl_pkg.sv
hw/aud_recorder.sv
hw/sample_mem.sv
hw/aud_dsp.sv
hw/rec_play_ctrl.sv
hw/aud_top.sv
tests/aud_tb.sv

//--- Makefile
# verilator build and run of the voice recorder testbench

SIM = obj_dir/Vaud_tb

all: run

$(SIM): filelist.f hw/*.sv tests/*.sv
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module aud_tb -Mdir obj_dir -o Vaud_tb

# pass only if the log holds the pass line
run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@grep -q "^TEST PASS$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module aud_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
